/* sim.f */
src/dna_pkg.sv
src/hostbus_pkg.sv
src/dna_port_model.sv
src/dna_reader.sv
src/id_regs.sv
src/device_id_top.sv
test/tb_device_id.sv

/* src/device_id_top.sv */
`timescale 1ns/1ps

module device_id_top #(
  parameter int                  dna_bits      = dna_pkg::default_dna_bits,
  parameter dna_pkg::dna_value_t sim_dna_value = dna_pkg::default_dna_value
) (
  input  logic                   dclk,       // assumed slow enough for the cell
  input  logic                   rst,
  input  hostbus_pkg::host_req_t req,
  input  logic                   req_valid,
  output hostbus_pkg::host_rsp_t rsp,
  output logic                   rsp_valid
);

  logic                 start;   // regs to reader
  logic                 load;    // reader to cell
  logic                 shift;
  logic                 dout;    // cell to reader
  dna_pkg::dna_status_t status;  // reader to regs
  dna_pkg::dna_value_t  dna;

  id_regs regs0 (
    .dclk      (dclk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .rsp       (rsp),
    .rsp_valid (rsp_valid),
    .start     (start),
    .status    (status),
    .dna       (dna)
  );

  dna_reader #(
    .dna_bits (dna_bits)
  ) reader0 (
    .dclk   (dclk),
    .rst    (rst),
    .start  (start),
    .load   (load),
    .shift  (shift),
    .dout   (dout),
    .status (status),
    .dna    (dna)
  );

  dna_port_model #(
    .dna_bits      (dna_bits),
    .sim_dna_value (sim_dna_value)
  ) cell0 (
    .dclk  (dclk),
    .load  (load),
    .shift (shift),
    .dout  (dout)
  );

endmodule

/* src/dna_pkg.sv */
package dna_pkg;

  // widest identity the reader and register map can hold
  localparam int max_dna_bits = 64;

  // identity word, narrower values sit right-aligned with zeros above
  typedef logic [max_dna_bits-1:0] dna_value_t;

  // reader state as seen by the host
  typedef struct packed {
    logic busy;   // read sequence in progress
    logic valid;  // full identity captured since last start
  } dna_status_t;

  // the 7-series cell is 57 bits long, the default for the design
  localparam int default_dna_bits = 57;

  // sample value of the vendor model, right-aligned
  localparam dna_value_t default_dna_value = dna_value_t'(57'h0_0006_7899_9821_2);

endpackage

/* src/dna_port_model.sv */
`timescale 1ns/1ps

// Behavioral stand-in for the serial identity cell. Its contents are unknown
// until the first load.
module dna_port_model #(
  parameter int                  dna_bits      = 57,  // cell length
  parameter dna_pkg::dna_value_t sim_dna_value = dna_pkg::default_dna_value
) (
  input  logic dclk,
  input  logic load,   // parallel load of the fixed value
  input  logic shift,  // move one bit toward dout
  output logic dout    // current msb of the cell
);

  logic [dna_bits-1:0] cell_sr;  // identity shift register

  always_ff @(posedge dclk) begin
    if (load) begin
      cell_sr <= sim_dna_value[dna_bits-1:0];     // load wins over shift
    end else if (shift) begin
      cell_sr <= {cell_sr[dna_bits-2:0], 1'b0};   // msb first with zero filling from below
    end
  end

  assign dout = cell_sr[dna_bits-1];  // msb always visible

endmodule

/* src/dna_reader.sv */
`timescale 1ns/1ps

// Load/shift sequencer for the identity cell. One load cycle, then one
// shift cycle per bit, then the collected word is published on dna.
module dna_reader #(
  parameter int dna_bits = 57  // identity width, 33 to 64
) (
  input  logic                 dclk,
  input  logic                 rst,
  input  logic                 start,   // one-cycle request, dropped while busy
  output logic                 load,    // to cell, first busy cycle
  output logic                 shift,   // to cell, one cycle per bit
  input  logic                 dout,    // current msb of the cell
  output dna_pkg::dna_status_t status,
  output dna_pkg::dna_value_t  dna      // last complete identity
);

  localparam int               cnt_w    = $clog2(dna_bits);
  localparam logic [cnt_w-1:0] last_bit = cnt_w'(dna_bits - 1);

  typedef enum logic [1:0] {
    idle_st,   // waiting for start
    load_st,   // cell takes its fixed value
    shift_st   // one bit per cycle
  } state_t;

  state_t              state;
  logic [cnt_w-1:0]    bit_cnt;   // bits taken in the shift phase
  logic [dna_bits-2:0] collect;   // bits gathered so far, newest at bit 0
  logic                valid_q;
  logic                last_shift;

  assign load       = (state == load_st);
  assign shift      = (state == shift_st);
  assign last_shift = shift && (bit_cnt == last_bit);  // final bit on dout now

  assign status.busy  = (state != idle_st);  // rises the cycle after start
  assign status.valid = valid_q;

  always_ff @(posedge dclk) begin
    if (rst) begin
      state   <= idle_st;
      bit_cnt <= '0;
      valid_q <= 1'b0;
      dna     <= '0;  // identity reads zero until the first capture
    end else begin
      case (state)
        idle_st: begin
          if (start) begin
            state   <= load_st;
            valid_q <= 1'b0;  // old dna kept, but no longer current
          end
        end
        load_st: begin
          state   <= shift_st;
          bit_cnt <= '0;
        end
        shift_st: begin
          bit_cnt <= bit_cnt + 1'b1;
          if (last_shift) begin
            state   <= idle_st;  // busy falls with valid rising
            valid_q <= 1'b1;
            dna     <= dna_pkg::dna_value_t'({collect, dout});  // zero-extended
          end
        end
        default: state <= idle_st;
      endcase
    end
  end

  // collecting register, only meaningful during the shift phase
  always_ff @(posedge dclk) begin
    if (shift) begin
      collect <= {collect[dna_bits-3:0], dout};
    end
  end

endmodule

/* src/hostbus_pkg.sv */
package hostbus_pkg;

  localparam int addr_w = 2;   // four word registers
  localparam int data_w = 32;  // host data path width

  // one request per req_valid strobe, no back-pressure
  typedef struct packed {
    logic              wr;     // 1 write, 0 read
    logic [addr_w-1:0] addr;   // word address
    logic [data_w-1:0] wdata;  // ignored on reads
  } host_req_t;

  // read data, returned one cycle after the request
  typedef struct packed {
    logic [data_w-1:0] rdata;
  } host_rsp_t;

  // register map
  localparam logic [addr_w-1:0] reg_status  = 2'd0;  // bit 0 busy, bit 1 valid
  localparam logic [addr_w-1:0] reg_dna_lsb = 2'd1;  // identity bits 31..0
  localparam logic [addr_w-1:0] reg_dna_msb = 2'd2;  // identity bits 63..32
  localparam logic [addr_w-1:0] reg_control = 2'd3;  // write bit 0 to start, reads zero

  // control register bit that requests a read
  localparam int ctrl_start_bit = 0;

endpackage

/* src/id_regs.sv */
`timescale 1ns/1ps

// Host register block. Requests are single-cycle strobes; each read is
// answered exactly one cycle later, writes get no response.
module id_regs (
  input  logic                  dclk,
  input  logic                  rst,
  input  hostbus_pkg::host_req_t req,
  input  logic                  req_valid,  // one cycle per request
  output hostbus_pkg::host_rsp_t rsp,
  output logic                  rsp_valid,  // one cycle after a read request
  output logic                  start,      // one cycle after a control write
  input  dna_pkg::dna_status_t  status,
  input  dna_pkg::dna_value_t   dna
);

  logic [hostbus_pkg::data_w-1:0] rd_mux;  // read data for the current address
  logic                           rd_req;
  logic                           ctrl_wr;

  assign rd_req  = req_valid && !req.wr;
  assign ctrl_wr = req_valid && req.wr
                   && (req.addr == hostbus_pkg::reg_control)
                   && req.wdata[hostbus_pkg::ctrl_start_bit];  // other writes ignored

  always_comb begin
    rd_mux = '0;
    case (req.addr)
      hostbus_pkg::reg_status: begin
        rd_mux[0] = status.busy;
        rd_mux[1] = status.valid;
      end
      hostbus_pkg::reg_dna_lsb: rd_mux = dna[31:0];
      hostbus_pkg::reg_dna_msb: rd_mux = dna[dna_pkg::max_dna_bits-1:32];
      default:                  rd_mux = '0;  // control reads back zero
    endcase
  end

  always_ff @(posedge dclk) begin
    if (rst) begin
      rsp_valid <= 1'b0;
      start     <= 1'b0;
    end else begin
      rsp_valid <= rd_req;
      start     <= ctrl_wr;  // reader drops it while busy
    end
  end

  // response data, qualified by rsp_valid
  always_ff @(posedge dclk) begin
    if (rd_req) begin
      rsp.rdata <= rd_mux;
    end
  end

endmodule

/* test/tb_device_id.sv */
`timescale 1ns/1ps

module tb_device_id;

  localparam int          dna_bits   = 57;                           // default cell length
  localparam logic [63:0] exp_dna    = 64'(57'h0_0006_7899_9821_2);  // default model value
  localparam int          max_cycles = 2000;  // directed run needs under 300

  logic                   dclk;
  logic                   rst;
  hostbus_pkg::host_req_t req;
  logic                   req_valid;
  hostbus_pkg::host_rsp_t rsp;
  logic                   rsp_valid;

  logic [15:0] lfsr_q       = 16'd41;  // stimulus source
  logic        exp_valid    = 1'b0;    // valid as the register map should show it
  logic [63:0] exp_word     = '0;      // identity as the register map should show it
  int          mismatch_cnt = 0;
  int          fail_cnt     = 0;
  int          cycle_cnt    = 0;

  device_id_top dut0 (
    .dclk      (dclk),
    .rst       (rst),
    .req       (req),
    .req_valid (req_valid),
    .rsp       (rsp),
    .rsp_valid (rsp_valid)
  );

  initial begin
    dclk = 1'b0;
    forever #5 dclk = ~dclk;  // 10 ns period
  end

  always @(posedge dclk) begin
    cycle_cnt++;
    if (cycle_cnt >= max_cycles) begin
      $display("Error: run stopped by timeout after %0d cycles", cycle_cnt);
      $display("Test failed");
      $finish;
    end
  end

  // x16 + x14 + x13 + x11 + 1 stepped once per bit taken
  function automatic logic lfsr_bit();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [31:0] lfsr_word();
    logic [31:0] w;
    w = '0;
    for (int i = 0; i < 32; i++) begin
      w = {w[30:0], lfsr_bit()};
    end
    return w;
  endfunction

  // register contents while the reader is idle
  function automatic hostbus_pkg::host_rsp_t expected_reg(input logic [1:0] addr);
    hostbus_pkg::host_rsp_t r;
    r.rdata = '0;
    case (addr)
      hostbus_pkg::reg_status:  r.rdata[1] = exp_valid;  // busy bit stays 0
      hostbus_pkg::reg_dna_lsb: r.rdata = exp_word[31:0];
      hostbus_pkg::reg_dna_msb: r.rdata = exp_word[63:32];
      default:                  r.rdata = '0;             // control reads zero
    endcase
    return r;
  endfunction

  task automatic check_rsp(input string name, input hostbus_pkg::host_rsp_t exp,
                           input hostbus_pkg::host_rsp_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected %h, actual %h", name, exp.rdata, act.rdata);
    end
  endtask

  task automatic check_status(input string name, input dna_pkg::dna_status_t exp,
                              input dna_pkg::dna_status_t act);
    if (act !== exp) begin
      mismatch_cnt++;
      $display("Mismatch in %s: expected busy=%b valid=%b, actual busy=%b valid=%b",
               name, exp.busy, exp.valid, act.busy, act.valid);
    end
  endtask

  // drives on a falling edge and returns on the next one with the response
  task automatic host_read(input string name, input logic [1:0] addr,
                           output hostbus_pkg::host_rsp_t got);
    req.wr    = 1'b0;
    req.addr  = addr;
    req.wdata = '0;
    req_valid = 1'b1;
    @(negedge dclk);
    req_valid = 1'b0;
    if (rsp_valid !== 1'b1) begin
      fail_cnt++;
      $display("Error in %s: no read response for address %0d", name, addr);
    end
    got = rsp;
  endtask

  task automatic host_write(input string name, input logic [1:0] addr, input logic [31:0] data);
    req.wr    = 1'b1;
    req.addr  = addr;
    req.wdata = data;
    req_valid = 1'b1;
    @(negedge dclk);
    req_valid = 1'b0;
    if (rsp_valid !== 1'b0) begin  // writes are never answered
      fail_cnt++;
      $display("Error in %s: write to address %0d got a response", name, addr);
    end
  endtask

  task automatic read_status(input string name, output dna_pkg::dna_status_t st);
    hostbus_pkg::host_rsp_t r;
    host_read(name, hostbus_pkg::reg_status, r);
    st.busy  = r.rdata[0];
    st.valid = r.rdata[1];
    if (r.rdata[31:2] !== '0) begin
      fail_cnt++;
      $display("Error in %s: status upper bits not zero (%h)", name, r.rdata);
    end
  endtask

  // polls status every cycle after a control write
  // with one extra control write in place of the poll at cycle extra_wr_at
  task automatic wait_read_done(input string name, input int extra_wr_at);
    dna_pkg::dna_status_t st;
    dna_pkg::dna_status_t busy_exp;
    dna_pkg::dna_status_t done_exp;
    int                   cycles;
    bit                   seen_busy;
    bit                   done;
    busy_exp.busy  = 1'b1;
    busy_exp.valid = 1'b0;   // a new start clears valid
    done_exp.busy  = 1'b0;
    done_exp.valid = 1'b1;
    cycles    = 0;
    seen_busy = 1'b0;
    done      = 1'b0;
    st        = '0;
    while (!done && cycles < dna_bits + 10) begin
      cycles++;
      if (cycles == extra_wr_at) begin
        host_write(name, hostbus_pkg::reg_control, 32'h1);  // must be dropped
      end else begin
        read_status(name, st);
        if (st.busy) begin
          seen_busy = 1'b1;
          check_status(name, busy_exp, st);
        end else if (seen_busy) begin
          done = 1'b1;
        end
      end
    end
    if (!done) begin
      fail_cnt++;
      $display("Error in %s: read never finished (busy seen: %0d)", name, seen_busy);
    end else begin
      check_status(name, done_exp, st);
      if (cycles > dna_bits + 3) begin
        fail_cnt++;
        $display("Error in %s: busy fell after %0d cycles, limit is %0d",
                 name, cycles, dna_bits + 3);
      end
      exp_valid = 1'b1;
      exp_word  = exp_dna;
    end
  endtask

  task automatic check_all_regs(input string name);
    hostbus_pkg::host_rsp_t r;
    for (int a = 0; a < 4; a++) begin
      host_read(name, a[1:0], r);
      check_rsp(name, expected_reg(a[1:0]), r);
    end
  endtask

  task automatic reset_values();
    dna_pkg::dna_status_t st;
    dna_pkg::dna_status_t idle_exp;
    idle_exp = '0;                      // neither busy nor valid
    check_all_regs("reset_values");     // all words zero
    read_status("reset_values", st);
    check_status("reset_values", idle_exp, st);
  endtask

  task automatic first_read();
    host_write("first_read", hostbus_pkg::reg_control, 32'h1);
    wait_read_done("first_read", -1);
    check_all_regs("first_read");
  endtask

  task automatic start_while_busy();
    host_write("start_while_busy", hostbus_pkg::reg_control, 32'h1);
    wait_read_done("start_while_busy", 20);  // second start mid-shift
    check_all_regs("start_while_busy");
  endtask

  task automatic restart_clears_valid();
    host_write("restart", hostbus_pkg::reg_control, 32'h1);
    wait_read_done("restart", -1);  // checks valid low during busy
    check_all_regs("restart");
  endtask

  task automatic ignored_writes();
    dna_pkg::dna_status_t st;
    dna_pkg::dna_status_t idle_exp;
    idle_exp.busy  = 1'b0;
    idle_exp.valid = 1'b1;
    host_write("ignored_writes", hostbus_pkg::reg_status, lfsr_word() | 32'h1);  // bit 0 set
    host_write("ignored_writes", hostbus_pkg::reg_dna_lsb, lfsr_word() | 32'h1);
    host_write("ignored_writes", hostbus_pkg::reg_dna_msb, lfsr_word() | 32'h1);
    host_write("ignored_writes", hostbus_pkg::reg_control, lfsr_word() & ~32'h1);  // bit 0 clear
    for (int i = 0; i < 4; i++) begin
      read_status("ignored_writes", st);  // a start would show busy here
      check_status("ignored_writes", idle_exp, st);
    end
    check_all_regs("ignored_writes");
  endtask

  task automatic random_reads();
    hostbus_pkg::host_rsp_t r;
    logic [1:0]             addr;
    for (int i = 0; i < 64; i++) begin
      addr[1] = lfsr_bit();
      addr[0] = lfsr_bit();
      host_read("random_reads", addr, r);  // back to back with no idle cycle
      check_rsp("random_reads", expected_reg(addr), r);
    end
    @(negedge dclk);
    if (rsp_valid !== 1'b0) begin
      fail_cnt++;
      $display("Error in random_reads: extra response after the last request");
    end
  endtask

  initial begin
    rst       = 1'b1;
    req       = '0;
    req_valid = 1'b0;
    repeat (5) @(posedge dclk);
    @(negedge dclk);
    rst = 1'b0;
    @(negedge dclk);

    reset_values();
    first_read();
    start_while_busy();
    restart_clears_valid();
    ignored_writes();
    random_reads();

    $display("summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt + fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
